// File: verilog/replay_pkg.sv
// Packet capture and replay engine shared widths, sizes and types
package replay_pkg;

  // Stream widths
  localparam int data_width  = 32;
  localparam int tuser_width = 32;

  // One-hot destination field, bit dst_port_pos+q selects queue q
  localparam int dst_port_pos = 24;

  localparam int num_queues = 2;

  // Memory split into equal regions, one per queue
  localparam int region_words  = 32;
  localparam int mem_words     = 64;
  localparam int max_pkt_words = 8;

  localparam int fifo_depth = 8;

  typedef logic [data_width-1:0]  data_t;
  typedef logic [tuser_width-1:0] tuser_t;

  typedef logic [5:0] mem_addr_t;
  // Offset in a region, wide enough to hold a full count
  typedef logic [5:0] region_ptr_t;
  // Last flag in the top bit, data below
  typedef logic [data_width:0] mem_word_t;

  typedef logic [0:0]  qid_t;
  typedef logic [31:0] drop_count_t;
  typedef logic [7:0]  replay_count_t;
  typedef logic [3:0]  fifo_level_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_store,
    wr_discard
  } wr_state_t;

  typedef enum logic {
    rd_idle,
    rd_run
  } rd_state_t;

endpackage

// File: verilog/queue_writer.sv
// Ingress classifier that stores packets into per-queue regions or drops them
`timescale 1ns/1ps

module queue_writer (
  input  logic                                                 axi_aclk,
  input  logic                                                 rst,
  input  replay_pkg::data_t                                    s_axis_tdata,
  input  replay_pkg::tuser_t                                   s_axis_tuser,
  input  logic                                                 s_axis_tvalid,
  output logic                                                 s_axis_tready,
  input  logic                                                 s_axis_tlast,
  input  logic                                                 replay_busy,
  output logic                                                 wr_en,
  output replay_pkg::mem_addr_t                                wr_addr,
  output replay_pkg::mem_word_t                                wr_word,
  output replay_pkg::region_ptr_t [replay_pkg::num_queues-1:0] tail_ptr,
  output replay_pkg::drop_count_t [replay_pkg::num_queues-1:0] drop_count
);

  replay_pkg::wr_state_t state;
  replay_pkg::qid_t      cur_q;
  replay_pkg::qid_t      sel_q;
  replay_pkg::qid_t      wr_q;
  logic                  accept_en;
  logic                  count_drop;
  logic                  hit;
  logic                  room;
  logic                  beat;

  // Input is held off while a replay runs
  assign s_axis_tready = accept_en && !replay_busy;
  assign beat = s_axis_tvalid && s_axis_tready;

  // Lowest set destination bit wins
  always_comb begin
    hit = 1'b0;
    sel_q = '0;
    for (int q = replay_pkg::num_queues - 1; q >= 0; q--) begin
      if (s_axis_tuser[replay_pkg::dst_port_pos + q]) begin
        hit = 1'b1;
        sel_q = replay_pkg::qid_t'(q);
      end
    end
  end

  // Room for a packet of the largest size
  assign room = (replay_pkg::region_words - int'(tail_ptr[sel_q])) >=
                replay_pkg::max_pkt_words;

  assign wr_q = (state == replay_pkg::wr_idle) ? sel_q : cur_q;

  assign wr_en = beat && (((state == replay_pkg::wr_idle) && hit && room) ||
                          (state == replay_pkg::wr_store));
  assign wr_addr = replay_pkg::mem_addr_t'(int'(wr_q) * replay_pkg::region_words +
                                           int'(tail_ptr[wr_q]));
  assign wr_word = {s_axis_tlast, s_axis_tdata};

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      state <= replay_pkg::wr_idle;
      accept_en <= 1'b0;
      cur_q <= '0;
      count_drop <= 1'b0;
      tail_ptr <= '0;
      drop_count <= '0;
    end else begin
      accept_en <= 1'b1;
      if (wr_en) begin
        tail_ptr[wr_q] <= replay_pkg::region_ptr_t'(tail_ptr[wr_q] + 1'b1);
      end
      if (beat) begin
        case (state)
          replay_pkg::wr_idle: begin
            cur_q <= sel_q;
            count_drop <= hit && !room;
            if (hit && room) begin
              if (!s_axis_tlast) begin
                state <= replay_pkg::wr_store;
              end
            end else if (s_axis_tlast) begin
              // Single word packet dropped on its first beat
              if (hit) begin
                drop_count[sel_q] <= drop_count[sel_q] + 1'b1;
              end
            end else begin
              state <= replay_pkg::wr_discard;
            end
          end
          replay_pkg::wr_store: begin
            if (s_axis_tlast) begin
              state <= replay_pkg::wr_idle;
            end
          end
          replay_pkg::wr_discard: begin
            if (s_axis_tlast) begin
              state <= replay_pkg::wr_idle;
              if (count_drop) begin
                drop_count[cur_q] <= drop_count[cur_q] + 1'b1;
              end
            end
          end
          default: state <= replay_pkg::wr_idle;
        endcase
      end
    end
  end

endmodule

// File: verilog/replay_sram.sv
// Dual-port packet memory, one write port and one registered read port
`timescale 1ns/1ps

module replay_sram (
  input  logic                  axi_aclk,
  input  logic                  wr_en,
  input  replay_pkg::mem_addr_t wr_addr,
  input  replay_pkg::mem_word_t wr_word,
  input  logic                  rd_en,
  input  replay_pkg::mem_addr_t rd_addr,
  output replay_pkg::mem_word_t rd_word
);

  replay_pkg::mem_word_t mem [replay_pkg::mem_words];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // Read data valid the cycle after rd_en
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

endmodule

// File: verilog/queue_reader.sv
// Replay sequencer reading queue regions round robin into the egress buffers
`timescale 1ns/1ps

module queue_reader (
  input  logic                                                 axi_aclk,
  input  logic                                                 rst,
  input  logic                                                 replay_start,
  input  replay_pkg::replay_count_t                            replay_count,
  input  replay_pkg::region_ptr_t [replay_pkg::num_queues-1:0] tail_ptr,
  input  replay_pkg::mem_word_t                                rd_word,
  input  replay_pkg::fifo_level_t [replay_pkg::num_queues-1:0] level,
  output logic                                                 rd_en,
  output replay_pkg::mem_addr_t                                rd_addr,
  output logic [replay_pkg::num_queues-1:0]                    push,
  output replay_pkg::mem_word_t                                push_word,
  output logic                                                 replay_busy
);

  replay_pkg::rd_state_t                                  state;
  replay_pkg::replay_count_t                              count_q;
  replay_pkg::region_ptr_t [replay_pkg::num_queues-1:0]   offset;
  replay_pkg::replay_count_t [replay_pkg::num_queues-1:0] pass;
  logic [replay_pkg::num_queues-1:0]                      done;
  logic [replay_pkg::num_queues-1:0]                      eligible;
  replay_pkg::qid_t                                       rr_ptr;
  replay_pkg::qid_t                                       rd_q;
  replay_pkg::qid_t                                       grant_q;
  logic                                                   rd_vld;
  logic                                                   grant_any;

  // The read in flight lands in its buffer this cycle
  always_comb begin
    for (int q = 0; q < replay_pkg::num_queues; q++) begin
      push[q] = rd_vld && (int'(rd_q) == q);
      eligible[q] = (state == replay_pkg::rd_run) && !done[q] &&
                    (int'(level[q]) + int'(push[q]) < replay_pkg::fifo_depth);
    end
  end

  // Search starts at the queue after the last one served
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_q = '0;
    for (int k = replay_pkg::num_queues; k >= 1; k--) begin
      idx = (int'(rr_ptr) + k) % replay_pkg::num_queues;
      if (eligible[idx]) begin
        grant_any = 1'b1;
        grant_q = replay_pkg::qid_t'(idx);
      end
    end
  end

  assign rd_en = grant_any;
  assign rd_addr = replay_pkg::mem_addr_t'(int'(grant_q) * replay_pkg::region_words +
                                           int'(offset[grant_q]));
  assign push_word = rd_word;
  assign replay_busy = (state == replay_pkg::rd_run);

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      state <= replay_pkg::rd_idle;
      count_q <= '0;
      offset <= '0;
      pass <= '0;
      done <= '0;
      rr_ptr <= '0;
      rd_q <= '0;
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= grant_any;
      if (grant_any) begin
        rd_q <= grant_q;
        rr_ptr <= grant_q;
      end
      case (state)
        replay_pkg::rd_idle: begin
          if (replay_start) begin
            state <= replay_pkg::rd_run;
            count_q <= replay_count;
            for (int q = 0; q < replay_pkg::num_queues; q++) begin
              offset[q] <= '0;
              pass[q] <= '0;
              done[q] <= (tail_ptr[q] == '0) || (replay_count == '0);
            end
          end
        end
        replay_pkg::rd_run: begin
          if (&done) begin
            state <= replay_pkg::rd_idle;
          end
          if (grant_any) begin
            if (int'(offset[grant_q]) + 1 >= int'(tail_ptr[grant_q])) begin
              // End of one pass over the queue
              offset[grant_q] <= '0;
              pass[grant_q] <= pass[grant_q] + 1'b1;
              if (int'(pass[grant_q]) + 1 >= int'(count_q)) begin
                done[grant_q] <= 1'b1;
              end
            end else begin
              offset[grant_q] <= offset[grant_q] + 1'b1;
            end
          end
        end
        default: state <= replay_pkg::rd_idle;
      endcase
    end
  end

endmodule

// File: verilog/egress_fifo.sv
// Per-queue egress buffer driving one master stream
`timescale 1ns/1ps

module egress_fifo (
  input  logic                    axi_aclk,
  input  logic                    rst,
  input  logic                    push,
  input  replay_pkg::mem_word_t   push_word,
  output replay_pkg::data_t       m_axis_tdata,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready,
  output logic                    m_axis_tlast,
  output replay_pkg::fifo_level_t level
);

  replay_pkg::mem_word_t                        buffer [replay_pkg::fifo_depth];
  logic [$clog2(replay_pkg::fifo_depth)-1:0] wr_ptr;
  logic [$clog2(replay_pkg::fifo_depth)-1:0] rd_ptr;
  logic                                         pop;

  // Head word stays put until taken
  assign m_axis_tvalid = (level != '0);
  assign m_axis_tdata = buffer[rd_ptr][replay_pkg::data_width-1:0];
  assign m_axis_tlast = buffer[rd_ptr][replay_pkg::data_width];
  assign pop = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      buffer[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
    end else begin
      if (push) begin
        if (int'(wr_ptr) == replay_pkg::fifo_depth - 1) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (int'(rd_ptr) == replay_pkg::fifo_depth - 1) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      case ({push, pop})
        2'b10: level <= level + 1'b1;
        2'b01: level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

// File: verilog/pcap_replay_top.sv
// Packet capture and replay engine top level with two replay queues
`timescale 1ns/1ps

module pcap_replay_top (
  input  logic                                                 axi_aclk,
  input  logic                                                 rst,
  input  replay_pkg::data_t                                    s_axis_tdata,
  input  replay_pkg::tuser_t                                   s_axis_tuser,
  input  logic                                                 s_axis_tvalid,
  output logic                                                 s_axis_tready,
  input  logic                                                 s_axis_tlast,
  input  logic                                                 replay_start,
  input  replay_pkg::replay_count_t                            replay_count,
  output logic                                                 replay_busy,
  output replay_pkg::data_t                                    m_axis_tdata_0,
  output logic                                                 m_axis_tvalid_0,
  input  logic                                                 m_axis_tready_0,
  output logic                                                 m_axis_tlast_0,
  output replay_pkg::data_t                                    m_axis_tdata_1,
  output logic                                                 m_axis_tvalid_1,
  input  logic                                                 m_axis_tready_1,
  output logic                                                 m_axis_tlast_1,
  output replay_pkg::drop_count_t [replay_pkg::num_queues-1:0] drop_count
);

  logic                                                 wr_en;
  replay_pkg::mem_addr_t                                wr_addr;
  replay_pkg::mem_word_t                                wr_word;
  replay_pkg::region_ptr_t [replay_pkg::num_queues-1:0] tail_ptr;
  logic                                                 rd_en;
  replay_pkg::mem_addr_t                                rd_addr;
  replay_pkg::mem_word_t                                rd_word;
  logic [replay_pkg::num_queues-1:0]                    push;
  replay_pkg::mem_word_t                                push_word;
  replay_pkg::fifo_level_t [replay_pkg::num_queues-1:0] level;

  queue_writer u_writer (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .replay_busy   (replay_busy),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_word       (wr_word),
    .tail_ptr      (tail_ptr),
    .drop_count    (drop_count)
  );

  replay_sram u_sram (
    .axi_aclk (axi_aclk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_word  (wr_word),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word)
  );

  queue_reader u_reader (
    .axi_aclk     (axi_aclk),
    .rst          (rst),
    .replay_start (replay_start),
    .replay_count (replay_count),
    .tail_ptr     (tail_ptr),
    .rd_word      (rd_word),
    .level        (level),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .push         (push),
    .push_word    (push_word),
    .replay_busy  (replay_busy)
  );

  egress_fifo u_egress_0 (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .push          (push[0]),
    .push_word     (push_word),
    .m_axis_tdata  (m_axis_tdata_0),
    .m_axis_tvalid (m_axis_tvalid_0),
    .m_axis_tready (m_axis_tready_0),
    .m_axis_tlast  (m_axis_tlast_0),
    .level         (level[0])
  );

  egress_fifo u_egress_1 (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .push          (push[1]),
    .push_word     (push_word),
    .m_axis_tdata  (m_axis_tdata_1),
    .m_axis_tvalid (m_axis_tvalid_1),
    .m_axis_tready (m_axis_tready_1),
    .m_axis_tlast  (m_axis_tlast_1),
    .level         (level[1])
  );

endmodule

// File: test/pcap_replay_sva.sv
// Protocol assertions on the replay engine ports, bound to the top level
`timescale 1ns/1ps

module pcap_replay_sva (
  input logic              axi_aclk,
  input logic              rst,
  input logic              s_axis_tready,
  input logic              replay_busy,
  input replay_pkg::data_t m_axis_tdata_0,
  input logic              m_axis_tvalid_0,
  input logic              m_axis_tready_0,
  input logic              m_axis_tlast_0,
  input replay_pkg::data_t m_axis_tdata_1,
  input logic              m_axis_tvalid_1,
  input logic              m_axis_tready_1,
  input logic              m_axis_tlast_1
);

  // Set on any assertion failure, watched by the testbench
  logic failed = 1'b0;

  reset_idle: assert property (@(posedge axi_aclk)
    rst |=> !s_axis_tready && !m_axis_tvalid_0 && !m_axis_tvalid_1 && !replay_busy)
    else begin
      $error("Ports not idle after reset");
      failed = 1'b1;
    end

  // Ingress is closed for the whole replay
  no_ingress_while_busy: assert property (@(posedge axi_aclk) disable iff (rst)
    !(s_axis_tready && replay_busy))
    else begin
      $error("s_axis_tready high while replay_busy");
      failed = 1'b1;
    end

  hold_out_0: assert property (@(posedge axi_aclk) disable iff (rst)
    m_axis_tvalid_0 && !m_axis_tready_0 |=>
      m_axis_tvalid_0 && $stable(m_axis_tdata_0) && $stable(m_axis_tlast_0))
    else begin
      $error("Output 0 changed while stalled");
      failed = 1'b1;
    end

  hold_out_1: assert property (@(posedge axi_aclk) disable iff (rst)
    m_axis_tvalid_1 && !m_axis_tready_1 |=>
      m_axis_tvalid_1 && $stable(m_axis_tdata_1) && $stable(m_axis_tlast_1))
    else begin
      $error("Output 1 changed while stalled");
      failed = 1'b1;
    end

endmodule

// File: test/tb_pcap_replay.sv
// Testbench for the packet capture and replay engine with a scoreboard per output
`timescale 1ns/1ps

module tb_pcap_replay;

  localparam int clk_period = 4;
  // Input packets plus four replay passes over a full memory, padded for stalls
  localparam int max_in_words = 20 * replay_pkg::max_pkt_words;
  localparam int max_out_words = 4 * replay_pkg::mem_words;
  localparam int watchdog_cycles = (max_in_words + max_out_words) * 8 + 200;

  logic                                                 axi_aclk = 1'b0;
  logic                                                 rst;
  replay_pkg::data_t                                    s_axis_tdata;
  replay_pkg::tuser_t                                   s_axis_tuser;
  logic                                                 s_axis_tvalid;
  logic                                                 s_axis_tready;
  logic                                                 s_axis_tlast;
  logic                                                 replay_start;
  replay_pkg::replay_count_t                            replay_count;
  logic                                                 replay_busy;
  replay_pkg::data_t                                    m_axis_tdata [2];
  logic [1:0]                                           m_axis_tvalid;
  logic [1:0]                                           m_axis_tready;
  logic [1:0]                                           m_axis_tlast;
  replay_pkg::drop_count_t [replay_pkg::num_queues-1:0] drop_count;

  integer                seed = 32'h1be8;
  string                 test_name;
  int                    model_tail [2];
  int                    model_drops [2];
  replay_pkg::mem_word_t stored [2][$];
  replay_pkg::mem_word_t expected [2][$];

  pcap_replay_top u_dut (
    .axi_aclk        (axi_aclk),
    .rst             (rst),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tuser    (s_axis_tuser),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tlast    (s_axis_tlast),
    .replay_start    (replay_start),
    .replay_count    (replay_count),
    .replay_busy     (replay_busy),
    .m_axis_tdata_0  (m_axis_tdata[0]),
    .m_axis_tvalid_0 (m_axis_tvalid[0]),
    .m_axis_tready_0 (m_axis_tready[0]),
    .m_axis_tlast_0  (m_axis_tlast[0]),
    .m_axis_tdata_1  (m_axis_tdata[1]),
    .m_axis_tvalid_1 (m_axis_tvalid[1]),
    .m_axis_tready_1 (m_axis_tready[1]),
    .m_axis_tlast_1  (m_axis_tlast[1]),
    .drop_count      (drop_count)
  );

  bind pcap_replay_top pcap_replay_sva u_sva (
    .axi_aclk        (axi_aclk),
    .rst             (rst),
    .s_axis_tready   (s_axis_tready),
    .replay_busy     (replay_busy),
    .m_axis_tdata_0  (m_axis_tdata_0),
    .m_axis_tvalid_0 (m_axis_tvalid_0),
    .m_axis_tready_0 (m_axis_tready_0),
    .m_axis_tlast_0  (m_axis_tlast_0),
    .m_axis_tdata_1  (m_axis_tdata_1),
    .m_axis_tvalid_1 (m_axis_tvalid_1),
    .m_axis_tready_1 (m_axis_tready_1),
    .m_axis_tlast_1  (m_axis_tlast_1)
  );

  always #(clk_period / 2) axi_aclk = ~axi_aclk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else
      fail_run($sformatf("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act));
  endtask

  function automatic int random_len();
    return 1 + ($unsigned($random(seed)) % replay_pkg::max_pkt_words);
  endfunction

  // Ready about three cycles in four
  always @(posedge axi_aclk) begin
    m_axis_tready[0] <= ($random(seed) & 3) != 0;
    m_axis_tready[1] <= ($random(seed) & 3) != 0;
  end

  // A word moves at the next rising edge when valid and ready are high here
  always @(negedge axi_aclk) begin
    for (int q = 0; q < 2; q++) begin
      if (!rst && m_axis_tvalid[q] && m_axis_tready[q]) begin
        if (expected[q].size() == 0) begin
          fail_run($sformatf("Unexpected word on output %0d during %s", q, test_name));
        end else begin
          check_value($sformatf("output %0d word", q), expected[q].pop_front(),
                      {m_axis_tlast[q], m_axis_tdata[q]});
        end
      end
    end
  end

  // dst holds the two destination bits, lowest set bit picks the queue
  task automatic send_packet(input logic [1:0] dst, input int len);
    replay_pkg::tuser_t    user;
    replay_pkg::mem_word_t word;
    int                    q;
    logic                  keep;
    user = $random(seed);
    user[replay_pkg::dst_port_pos +: 2] = dst;
    q = dst[0] ? 0 : 1;
    keep = (dst != 2'b00) && (replay_pkg::region_words - model_tail[q] >=
                              replay_pkg::max_pkt_words);
    if (dst != 2'b00 && !keep) begin
      model_drops[q]++;
    end
    for (int i = 0; i < len; i++) begin
      word = {i == len - 1, replay_pkg::data_t'($random(seed))};
      if (keep) begin
        stored[q].push_back(word);
        model_tail[q]++;
      end
      @(posedge axi_aclk);
      s_axis_tvalid <= 1'b1;
      s_axis_tdata <= word[31:0];
      s_axis_tlast <= word[32];
      s_axis_tuser <= user;
      do @(negedge axi_aclk); while (!s_axis_tready);
    end
    @(posedge axi_aclk);
    s_axis_tvalid <= 1'b0;
    @(negedge axi_aclk);
    check_value("drop_count[0]", model_drops[0], drop_count[0]);
    check_value("drop_count[1]", model_drops[1], drop_count[1]);
  endtask

  task automatic run_replay(input int count);
    for (int q = 0; q < 2; q++) begin
      for (int p = 0; p < count; p++) begin
        foreach (stored[q][i]) expected[q].push_back(stored[q][i]);
      end
    end
    @(posedge axi_aclk);
    replay_start <= 1'b1;
    replay_count <= replay_pkg::replay_count_t'(count);
    @(posedge axi_aclk);
    replay_start <= 1'b0;
    do @(negedge axi_aclk); while (!replay_busy);
    do @(negedge axi_aclk); while (replay_busy);
    while (expected[0].size() + expected[1].size() != 0) @(negedge axi_aclk);
    // Extra cycles so that any stray word shows up
    repeat (8) @(negedge axi_aclk);
    check_value("tvalid after drain", 0, m_axis_tvalid);
  endtask

  initial begin
    rst = 1'b1;
    s_axis_tdata = '0;
    s_axis_tuser = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    replay_start = 1'b0;
    replay_count = '0;
    m_axis_tready = '0;
    model_tail = '{0, 0};
    model_drops = '{0, 0};
    test_name = "reset";
    repeat (10) @(posedge axi_aclk);
    rst <= 1'b0;

    // Both queues, both bits set, and packets with no destination
    test_name = "classify";
    send_packet(2'b01, random_len());
    send_packet(2'b10, random_len());
    send_packet(2'b11, random_len());
    send_packet(2'b10, random_len());
    send_packet(2'b00, random_len());
    send_packet(2'b01, random_len());
    send_packet(2'b10, random_len());
    send_packet(2'b00, random_len());
    test_name = "replay_x3";
    run_replay(3);
    test_name = "replay_x0";
    run_replay(0);

    // Fill queue 0 until a full packet no longer fits
    test_name = "drop";
    while (replay_pkg::region_words - model_tail[0] >= replay_pkg::max_pkt_words) begin
      send_packet(2'b01, random_len());
    end
    repeat (3) send_packet(2'b01, random_len());
    send_packet(2'b00, random_len());
    check_value("dropped packets", 3, drop_count[0]);
    test_name = "replay_after_drop";
    run_replay(1);

    if (!u_dut.u_sva.failed) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run("A protocol assertion failed on the DUT ports");
    end
  end

  initial begin
    @(posedge u_dut.u_sva.failed);
    fail_run("A protocol assertion failed on the DUT ports");
  end

  initial begin
    #(watchdog_cycles * clk_period);
    fail_run("Timeout, the run did not finish within the cycle budget");
  end

endmodule

// File: list.f
verilog/replay_pkg.sv
verilog/queue_writer.sv
verilog/replay_sram.sv
verilog/queue_reader.sv
verilog/egress_fifo.sv
verilog/pcap_replay_top.sv
test/pcap_replay_sva.sv
test/tb_pcap_replay.sv

// File: Bender.yml
package:
  name: pcap_replay

sources:
  - verilog/replay_pkg.sv
  - verilog/queue_writer.sv
  - verilog/replay_sram.sv
  - verilog/queue_reader.sv
  - verilog/egress_fifo.sv
  - verilog/pcap_replay_top.sv
  - target: test
    files:
      - test/pcap_replay_sva.sv
      - test/tb_pcap_replay.sv
